//--- hw/display_types_pkg.sv
`default_nettype none

package display_types_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths of the display path
  ////////////////////////////////////////////////////////////////////

  localparam int VALUE_W    = 24;  // Signed input value
  localparam int LED_W      = 16;
  localparam int NUM_DIGITS = 8;   // Digit 7 is the leftmost
  localparam int MAG_DIGITS = 7;   // Largest magnitude 8388608

  typedef logic signed [VALUE_W-1:0] display_value_t;
  typedef logic [LED_W-1:0]          led_pattern_t;

  // 0 to 9 decimal, anything else is a special glyph
  typedef logic [3:0]                digit_code_t;

  // One-cold, bit 7 is the leftmost digit
  typedef logic [NUM_DIGITS-1:0]     digit_sel_t;

  // Active low, dp g f e d c b a
  typedef logic [7:0]                seg_pattern_t;

  ////////////////////////////////////////////////////////////////////
  // Converter FSM
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CONV_IDLE,   // Waiting for a start pulse
    CONV_SHIFT,  // One input bit per cycle
    CONV_DONE    // Publish digits
  } conv_state_t;

endpackage

`default_nettype wire

//--- hw/display_glyph_pkg.sv
`default_nettype none

package display_glyph_pkg;

  // Digit code that selects the minus glyph
  localparam logic [3:0] MINUS_CODE = 4'd15;

  ////////////////////////////////////////////////////////////////////
  // Segment glyphs, active low, bit order dp g f e d c b a
  ////////////////////////////////////////////////////////////////////

  localparam logic [7:0] GLYPH_0     = 8'hC0;  // a b c d e f
  localparam logic [7:0] GLYPH_1     = 8'hF9;  // b c
  localparam logic [7:0] GLYPH_2     = 8'hA4;
  localparam logic [7:0] GLYPH_3     = 8'hB0;
  localparam logic [7:0] GLYPH_4     = 8'h99;
  localparam logic [7:0] GLYPH_5     = 8'h92;
  localparam logic [7:0] GLYPH_6     = 8'h82;
  localparam logic [7:0] GLYPH_7     = 8'hF8;
  localparam logic [7:0] GLYPH_8     = 8'h80;  // Everything but dp
  localparam logic [7:0] GLYPH_9     = 8'h90;
  localparam logic [7:0] GLYPH_MINUS = 8'hBF;  // g only

  // Codes without a shape
  localparam logic [7:0] GLYPH_BLANK = 8'hFF;

endpackage

`default_nettype wire

//--- hw/value_capture.sv
`timescale 1ns/10ps
`default_nettype none

module value_capture import display_types_pkg::*; (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           req,
  input  display_value_t      value,
  input  led_pattern_t        led_pattern,
  input  wire logic           blink_need,
  input  wire logic           conv_done,
  output logic                ack,
  output logic                conv_start,
  output display_value_t      conv_value,
  output led_pattern_t        led_out,
  output logic                blink_en
);

  typedef enum logic [1:0] {
    CAP_IDLE,    // Waiting for req
    CAP_LAUNCH,  // Fire the converter
    CAP_WAIT,    // Conversion running
    CAP_HOLD     // ack high until req drops
  } cap_state_t;

  cap_state_t state;
  logic       take;

  assign take = (state == CAP_IDLE) && req && !ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= CAP_IDLE;
      ack        <= 1'b0;
      conv_start <= 1'b0;
      led_out    <= '0;
      blink_en   <= 1'b0;
    end else begin
      conv_start <= 1'b0;  // Single-cycle pulse
      case (state)
        CAP_IDLE: begin
          if (take) begin
            led_out  <= led_pattern;  // Side outputs follow the latch
            blink_en <= blink_need;
            state    <= CAP_LAUNCH;
          end
        end
        CAP_LAUNCH: begin
          conv_start <= 1'b1;
          state      <= CAP_WAIT;
        end
        CAP_WAIT: begin
          if (conv_done) begin
            ack   <= 1'b1;  // Digits are in the scanner now
            state <= CAP_HOLD;
          end
        end
        CAP_HOLD: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= CAP_IDLE;
          end
        end
        default: state <= CAP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) conv_value <= value;
  end

  // Host must still be requesting when the transfer completes
  ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
    else $error("ack rose while req was low");

endmodule

`default_nettype wire

//--- hw/bcd_converter.sv
`timescale 1ns/10ps
`default_nettype none

module bcd_converter import display_types_pkg::*, display_glyph_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       conv_start,
  input  display_value_t  conv_value,
  output logic            conv_done,
  output digit_code_t     digit0,
  output digit_code_t     digit1,
  output digit_code_t     digit2,
  output digit_code_t     digit3,
  output digit_code_t     digit4,
  output digit_code_t     digit5,
  output digit_code_t     digit6,
  output digit_code_t     digit7
);

  localparam int BCD_W = 4 * MAG_DIGITS;
  localparam int CNT_W = $clog2(VALUE_W + 1);

  conv_state_t        state;
  logic [CNT_W-1:0]   bit_cnt;
  logic               neg_q;
  logic [VALUE_W-1:0] bin_q;    // Magnitude, shifted out MSB first
  logic [BCD_W-1:0]   bcd_q;
  logic [BCD_W-1:0]   bcd_adj;

  // Add 3 to every BCD digit above 4 before the shift
  always_comb begin
    bcd_adj = bcd_q;
    for (int i = 0; i < MAG_DIGITS; i++) begin
      if (bcd_q[4*i +: 4] > 4'd4) bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Control: load, 24 shifts, done
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= CONV_IDLE;
      bit_cnt   <= '0;
      conv_done <= 1'b0;
    end else begin
      conv_done <= 1'b0;
      case (state)
        CONV_IDLE: begin
          if (conv_start) begin
            bit_cnt <= '0;
            state   <= CONV_SHIFT;
          end
        end
        CONV_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(VALUE_W - 1)) state <= CONV_DONE;
        end
        CONV_DONE: begin
          conv_done <= 1'b1;  // Same edge as the digit outputs
          state     <= CONV_IDLE;
        end
        default: state <= CONV_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == CONV_IDLE && conv_start) begin
      neg_q <= conv_value[VALUE_W-1];
      bin_q <= conv_value[VALUE_W-1] ? -conv_value : conv_value;  // -8388608 wraps to 0x800000
      bcd_q <= '0;
    end else if (state == CONV_SHIFT) begin
      bcd_q <= {bcd_adj[BCD_W-2:0], bin_q[VALUE_W-1]};
      bin_q <= {bin_q[VALUE_W-2:0], 1'b0};
    end else if (state == CONV_DONE) begin
      digit0 <= bcd_q[3:0];
      digit1 <= bcd_q[7:4];
      digit2 <= bcd_q[11:8];
      digit3 <= bcd_q[15:12];
      digit4 <= bcd_q[19:16];
      digit5 <= bcd_q[23:20];
      digit6 <= bcd_q[27:24];
      digit7 <= neg_q ? MINUS_CODE : 4'd0;  // Sign digit
    end
  end

  // Capture stage must wait for the previous result
  start_in_idle : assert property (@(posedge clk) disable iff (!rst_n)
    conv_start |-> state == CONV_IDLE)
    else $error("conv_start while converter busy");

endmodule

`default_nettype wire

//--- hw/digit_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module digit_scanner import display_types_pkg::*; #(
  parameter int SCAN_DIV = 100000
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  conv_done,
  input  digit_code_t digit0,
  input  digit_code_t digit1,
  input  digit_code_t digit2,
  input  digit_code_t digit3,
  input  digit_code_t digit4,
  input  digit_code_t digit5,
  input  digit_code_t digit6,
  input  digit_code_t digit7,
  output digit_sel_t  scan_sel,
  output digit_code_t scan_code
);

  localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  digit_code_t      digit_q [NUM_DIGITS];
  logic [CNT_W-1:0] div_cnt;
  logic             scan_tick;
  digit_sel_t       next_sel;
  digit_code_t      next_code;

  // Displayed digits, replaced as a whole
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_DIGITS; i++) digit_q[i] <= '0;
    end else if (conv_done) begin
      digit_q[0] <= digit0;
      digit_q[1] <= digit1;
      digit_q[2] <= digit2;
      digit_q[3] <= digit3;
      digit_q[4] <= digit4;
      digit_q[5] <= digit5;
      digit_q[6] <= digit6;
      digit_q[7] <= digit7;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Scan rate
  ////////////////////////////////////////////////////////////////////

  assign scan_tick = (div_cnt == CNT_W'(SCAN_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)         div_cnt <= '0;
    else if (scan_tick) div_cnt <= '0;
    else                div_cnt <= div_cnt + 1'b1;
  end

  // All ones only before the first step, then start at digit 7
  always_comb begin
    if (&scan_sel) next_sel = {1'b0, {(NUM_DIGITS-1){1'b1}}};
    else           next_sel = {scan_sel[0], scan_sel[NUM_DIGITS-1:1]};
    next_code = '0;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      if (!next_sel[i]) next_code = digit_q[i];
    end
  end

  // Code sampled only on a step, so a digit never changes mid-slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_sel  <= '1;
      scan_code <= '0;
    end else if (scan_tick) begin
      scan_sel  <= next_sel;
      scan_code <= next_code;
    end
  end

  one_digit_on : assert property (@(posedge clk) disable iff (!rst_n)
    scan_tick |=> $onehot(~scan_sel))
    else $error("scan_sel not one-cold after step");

endmodule

`default_nettype wire

//--- hw/seg_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module seg_encoder import display_types_pkg::*, display_glyph_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  digit_sel_t  scan_sel,
  input  digit_code_t scan_code,
  output digit_sel_t  seg_en,
  output seg_pattern_t seg_out
);

  seg_pattern_t glyph;

  always_comb begin
    case (scan_code)
      4'd0:       glyph = GLYPH_0;
      4'd1:       glyph = GLYPH_1;
      4'd2:       glyph = GLYPH_2;
      4'd3:       glyph = GLYPH_3;
      4'd4:       glyph = GLYPH_4;
      4'd5:       glyph = GLYPH_5;
      4'd6:       glyph = GLYPH_6;
      4'd7:       glyph = GLYPH_7;
      4'd8:       glyph = GLYPH_8;
      4'd9:       glyph = GLYPH_9;
      MINUS_CODE: glyph = GLYPH_MINUS;
      default:    glyph = GLYPH_BLANK;  // Unused codes stay dark
    endcase
  end

  // Enable delayed with the pattern so both switch together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg_en  <= '1;  // All digits off
      seg_out <= GLYPH_BLANK;
    end else begin
      seg_en  <= scan_sel;
      seg_out <= glyph;
    end
  end

endmodule

`default_nettype wire

//--- hw/blink_timer.sv
`timescale 1ns/10ps
`default_nettype none

module blink_timer #(
  parameter int BLINK_DIV = 5000000
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic blink_en,
  output logic      blink_out
);

  localparam int CNT_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;

  logic [CNT_W-1:0] half_cnt;  // Cycles into the current half period
  logic             half_end;

  assign half_end = (half_cnt == CNT_W'(BLINK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt  <= '0;
      blink_out <= 1'b0;
    end else if (!blink_en) begin
      half_cnt  <= '0;  // Restart from a clean phase
      blink_out <= 1'b0;
    end else if (half_end) begin
      half_cnt  <= '0;
      blink_out <= ~blink_out;
    end else begin
      half_cnt  <= half_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/display_top.sv
`timescale 1ns/10ps
`default_nettype none

module display_top import display_types_pkg::*; #(
  parameter int SCAN_DIV  = 100000,   // clk cycles per digit
  parameter int BLINK_DIV = 5000000   // clk cycles per blink half period
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     req,
  input  display_value_t value,
  input  led_pattern_t  led_pattern,
  input  wire logic     blink_need,
  output logic          ack,
  output digit_sel_t    seg_en,
  output seg_pattern_t  seg_out,
  output led_pattern_t  led_out,
  output logic          blink_out
);

  logic           conv_start;
  logic           conv_done;
  logic           blink_en;
  display_value_t conv_value;
  digit_code_t    digit0, digit1, digit2, digit3;
  digit_code_t    digit4, digit5, digit6, digit7;
  digit_sel_t     scan_sel;
  digit_code_t    scan_code;

  ////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////

  value_capture capture_i (
    .clk(clk), .rst_n(rst_n),
    .req(req), .value(value), .led_pattern(led_pattern), .blink_need(blink_need),
    .conv_done(conv_done),
    .ack(ack), .conv_start(conv_start), .conv_value(conv_value),
    .led_out(led_out), .blink_en(blink_en)
  );

  bcd_converter convert_i (
    .clk(clk), .rst_n(rst_n),
    .conv_start(conv_start), .conv_value(conv_value), .conv_done(conv_done),
    .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
    .digit4(digit4), .digit5(digit5), .digit6(digit6), .digit7(digit7)
  );

  ////////////////////////////////////////////////////////////////////
  // Display side
  ////////////////////////////////////////////////////////////////////

  digit_scanner #(.SCAN_DIV(SCAN_DIV)) scan_i (
    .clk(clk), .rst_n(rst_n), .conv_done(conv_done),
    .digit0(digit0), .digit1(digit1), .digit2(digit2), .digit3(digit3),
    .digit4(digit4), .digit5(digit5), .digit6(digit6), .digit7(digit7),
    .scan_sel(scan_sel), .scan_code(scan_code)
  );

  seg_encoder encode_i (
    .clk(clk), .rst_n(rst_n),
    .scan_sel(scan_sel), .scan_code(scan_code),
    .seg_en(seg_en), .seg_out(seg_out)
  );

  blink_timer #(.BLINK_DIV(BLINK_DIV)) blink_i (
    .clk(clk), .rst_n(rst_n), .blink_en(blink_en), .blink_out(blink_out)
  );

endmodule

`default_nettype wire

//--- verification/display_tb.sv
`timescale 1ns/10ps
`default_nettype none

module display_tb import display_types_pkg::*;;

  localparam int SCAN_DIV      = 8;
  localparam int BLINK_DIV     = 50;
  localparam int NUM_TRANSFERS = 20;
  localparam int ACK_TIMEOUT   = 100;           // Cycles, nominal latency is 28
  localparam int STEP_TIMEOUT  = 4 * SCAN_DIV;
  localparam logic [7:0] MINUS_SHAPE = 8'hBF;   // g only

  logic           clk;
  logic           rst_n;
  logic           req;
  display_value_t value;
  led_pattern_t   led_pattern;
  logic           blink_need;
  logic           ack;
  digit_sel_t     seg_en;
  seg_pattern_t   seg_out;
  led_pattern_t   led_out;
  logic           blink_out;

  logic [31:0]    lfsr_state;
  logic [7:0]     model_glyph [8];   // Expected pattern per digit position
  logic [7:0]     prev_en;
  logic [7:0]     next_en;
  int             exp_digit;         // Position the scan should light next
  logic           prev_ack;
  logic [31:0]    tmp;
  logic [31:0]    shift;
  display_value_t stim_value;
  led_pattern_t   stim_leds;
  logic           stim_blink;
  logic           seen_blink_on;
  logic           seen_blink_off;

  display_top #(.SCAN_DIV(SCAN_DIV), .BLINK_DIV(BLINK_DIV)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .req(req), .value(value), .led_pattern(led_pattern), .blink_need(blink_need),
    .ack(ack), .seg_en(seg_en), .seg_out(seg_out),
    .led_out(led_out), .blink_out(blink_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("%s at %0t ns", what, $time);
    stop_run();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;   // Taps 32 22 2 1
    return s >> 1;
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic [7:0] digit_glyph(input int code);
    case (code)
      0:       return 8'hC0;
      1:       return 8'hF9;
      2:       return 8'hA4;
      3:       return 8'hB0;
      4:       return 8'h99;
      5:       return 8'h92;
      6:       return 8'h82;
      7:       return 8'hF8;
      8:       return 8'h80;
      9:       return 8'h90;
      default: return 8'hFF;
    endcase
  endfunction

  // Sign on digit 7, magnitude with leading zeros below
  task automatic build_model(input display_value_t val);
    int mag;
    mag = (val < 0) ? -int'(val) : int'(val);
    for (int d = 0; d < 7; d++) begin
      model_glyph[d] = digit_glyph(mag % 10);
      mag = mag / 10;
    end
    model_glyph[7] = (val < 0) ? MINUS_SHAPE : digit_glyph(0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && ack && !prev_ack) begin
      assert (req) else report_value("req", 32'd1, 32'(req));   // ack only answers a request
    end
    prev_ack = ack;
  end

  always @(negedge clk) begin
    if (rst_n && seg_en != prev_en) begin
      exp_digit = (exp_digit == 0) ? NUM_DIGITS - 1 : exp_digit - 1;  // 7 down to 0, wrap
      next_en = ~(8'd1 << exp_digit);
      assert ($onehot(~seg_en)) else report_problem("seg_en is not one-cold after a scan step");
      assert (seg_en == next_en) else report_value("seg_en", 32'(next_en), 32'(seg_en));
    end
    prev_en = seg_en;
  end

  //////////////////////////////////////////////////////////////////////
  // Host driver and checkers
  //////////////////////////////////////////////////////////////////////

  // Next change of seg_en, with ack held the whole time
  task automatic wait_scan_step();
    int waited;
    logic [7:0] start_en;
    waited = 0;
    start_en = seg_en;
    while (seg_en == start_en && waited < STEP_TIMEOUT) begin
      @(negedge clk);
      waited++;
      assert (ack) else report_value("ack", 32'd1, 32'(ack));
    end
    assert (seg_en != start_en) else report_problem("scan did not step within the timeout");
  endtask

  task automatic run_transfer(input display_value_t val, input led_pattern_t leds,
                              input logic blink);
    int waited;
    int pos;
    build_model(val);
    @(posedge clk);
    value       <= val;
    led_pattern <= leds;
    blink_need  <= blink;
    @(posedge clk);
    req <= 1'b1;   // Data settled one cycle earlier
    waited = 0;
    while (!ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (ack) else report_problem("ack did not rise within the timeout");
    assert (led_out == leds) else report_value("led_out", 32'(leds), 32'(led_out));

    wait_scan_step();   // May still carry the old digit
    for (int s = 0; s < NUM_DIGITS; s++) begin
      wait_scan_step();
      pos = 0;
      for (int i = 0; i < NUM_DIGITS; i++) begin
        if (!seg_en[i]) pos = i;
      end
      assert (seg_out == model_glyph[pos])
        else report_value("seg_out", 32'(model_glyph[pos]), 32'(seg_out));
    end

    @(posedge clk);
    req <= 1'b0;
    waited = 0;
    while (ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    assert (!ack) else report_problem("ack did not fall after req dropped");
  endtask

  // Fixed observation window of four half periods
  task automatic check_blink(input logic expect_on);
    int toggles;
    logic last_out;
    toggles = 0;
    last_out = blink_out;
    for (int i = 0; i < 4 * BLINK_DIV; i++) begin
      @(negedge clk);
      if (!expect_on) begin
        assert (blink_out == 1'b0) else report_value("blink_out", 32'd0, 32'(blink_out));
      end
      if (blink_out != last_out) toggles++;
      last_out = blink_out;
    end
    if (expect_on) begin
      assert (toggles >= 2) else report_problem("blink_out toggled fewer than twice");
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    req            = 1'b0;
    value          = '0;
    led_pattern    = '0;
    blink_need     = 1'b0;
    prev_ack       = 1'b0;
    prev_en        = 8'hFF;
    exp_digit      = 0;
    lfsr_state     = 32'd37;
    seen_blink_on  = 1'b0;
    seen_blink_off = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (ack == 1'b0) else report_value("ack", 32'd0, 32'(ack));
    assert (led_out == '0) else report_value("led_out", 32'd0, 32'(led_out));
    assert (blink_out == 1'b0) else report_value("blink_out", 32'd0, 32'(blink_out));

    for (int t = 0; t < NUM_TRANSFERS; t++) begin
      tmp = rand_bits(24);
      shift = rand_bits(4);
      case (t)
        0:       stim_value = 24'h800000;   // Most negative
        1:       stim_value = 24'h7FFFFF;
        2:       stim_value = 24'h000000;
        3:       stim_value = 24'hFFFFFF;
        default: stim_value = display_value_t'(tmp[23:0]) >>> shift[3:0];
      endcase
      tmp = rand_bits(16);
      stim_leds = tmp[15:0];
      tmp = rand_bits(1);
      stim_blink = tmp[0];
      if (stim_blink) seen_blink_on = 1'b1;
      else            seen_blink_off = 1'b1;
      run_transfer(stim_value, stim_leds, stim_blink);
      check_blink(stim_blink);
      tmp = rand_bits(3);
      repeat (tmp) @(posedge clk);   // Idle gap
    end

    assert (seen_blink_on && seen_blink_off)
      else report_problem("blink_need never took both values");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- display_top.f
hw/display_types_pkg.sv
hw/display_glyph_pkg.sv
hw/value_capture.sv
hw/bcd_converter.sv
hw/digit_scanner.sv
hw/seg_encoder.sv
hw/blink_timer.sv
hw/display_top.sv
verification/display_tb.sv

//--- Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= display_tb
FILELIST  ?= display_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
